// File: hw/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// pc after reset, one word below the first fetch address
`define FETCH_RESET_PC      32'h1bfffffc

// exception entry until software writes a new one
`define FETCH_EENTRY_RESET  32'h1c008000

// major opcodes, inst[31:26]
`define OP_B                6'b010100
`define OP_BL               6'b010101

`endif

// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // one fetched word, read either as a branch or as plain bits
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;   // offs[15:0]
            logic [9:0]  offs_hi;   // offs[25:16]
        } br;
        logic [31:0] raw;
    } inst_word_u;

endpackage

`default_nettype wire

// File: hw/fetch_id_if.sv
`default_nettype none

interface fetch_id_if
    import fetch_pkg::*;
();
    // fetch -> decode
    logic        valid;
    inst_word_u  inst;
    logic [31:0] pc;
    logic        adef;       // fetch address not word aligned

    // decode -> fetch
    logic        allowin;
    logic        br_taken;   // one cycle, first held cycle of a B/BL
    logic [31:0] br_target;

    modport fetch (
        output valid, inst, pc, adef,
        input  allowin, br_taken, br_target
    );

    modport decode (
        input  valid, inst, pc, adef,
        output allowin, br_taken, br_target
    );
endinterface

`default_nettype wire

// File: hw/if_stage.sv
`default_nettype none
`include "fetch_macros.svh"

module if_stage
    import fetch_pkg::*;
(
    input  wire         clk,
    input  wire         resetn,
    output logic        inst_sram_req,
    output logic        inst_sram_wr,
    output logic [1:0]  inst_sram_size,
    output logic [3:0]  inst_sram_wstrb,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  wire         inst_sram_addr_ok,
    input  wire         inst_sram_data_ok,
    input  wire  [31:0] inst_sram_rdata,
    input  wire         flush,
    input  wire  [31:0] excep_entry,
    fetch_id_if.fetch   fid
);
    logic        fetch_en;          // set on the first edge out of reset
    logic [31:0] pc;                // address of the last accepted request
    logic        br_pend;           // redirect seen but its request not yet taken
    logic [31:0] br_target_reg;
    logic [1:0]  outst;             // accepted, response still due
    logic [1:0]  disc_cnt;          // responses left to drop after a redirect

    // pre-IF: request accepted while IF was busy
    logic        pre_if_reqed;
    logic [31:0] pre_if_pc;
    inst_word_u  pre_if_ir;
    logic        pre_if_ir_valid;

    // IF: oldest live request, word waits here for decode
    logic        if_valid;
    logic [31:0] if_pc;
    inst_word_u  if_ir;
    logic        if_ir_valid;

    logic        cancel;
    logic        accept;
    logic        transfer;
    logic        live_data;
    logic        data_for_if;
    logic        data_for_pre;
    logic        if_allowin;
    logic        pre_move;
    logic        slot_ok;
    logic [31:0] seq_pc;
    logic [31:0] pre_pc;

    assign cancel   = flush | fid.br_taken;
    assign accept   = inst_sram_req & inst_sram_addr_ok;
    assign transfer = fid.valid & fid.allowin;

    // responses come back in order, so the oldest live one belongs to IF
    assign live_data    = inst_sram_data_ok & (disc_cnt == 2'd0);
    assign data_for_if  = live_data & if_valid & ~if_ir_valid;
    assign data_for_pre = live_data & if_ir_valid;

    assign if_allowin = ~if_valid | transfer;
    assign pre_move   = pre_if_reqed & if_allowin;
    assign slot_ok    = cancel | ~pre_if_reqed | if_allowin;

    // next fetch address, flush wins over any branch
    assign seq_pc = pc + 32'd4;
    assign pre_pc = flush        ? excep_entry :
                    br_pend      ? br_target_reg :
                    fid.br_taken ? fid.br_target :
                                   seq_pc;

    assign inst_sram_req   = fetch_en & (outst != 2'd2) & slot_ok;
    assign inst_sram_addr  = pre_pc;
    assign inst_sram_wr    = 1'b0;
    assign inst_sram_size  = 2'd2;     // word reads only
    assign inst_sram_wstrb = 4'b0000;
    assign inst_sram_wdata = 32'd0;

    // wrong-path word in the redirect cycle must not reach decode
    assign fid.valid = if_valid & (if_ir_valid | data_for_if) & ~cancel;
    assign fid.inst  = if_ir_valid ? if_ir : inst_word_u'(inst_sram_rdata);
    assign fid.pc    = if_pc;
    assign fid.adef  = |if_pc[1:0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_en <= 1'b0;
            pc       <= `FETCH_RESET_PC;
            br_pend  <= 1'b0;
            outst    <= 2'd0;
            disc_cnt <= 2'd0;
        end else begin
            fetch_en <= 1'b1;
            if (accept) begin
                pc <= pre_pc;
            end
            if (cancel && !accept) begin
                br_pend <= 1'b1;
            end else if (accept) begin
                br_pend <= 1'b0;
            end
            outst <= outst + {1'b0, accept} - {1'b0, inst_sram_data_ok};
            // everything in flight before the redirect is wrong path
            if (cancel) begin
                disc_cnt <= outst - {1'b0, inst_sram_data_ok};
            end else if (inst_sram_data_ok && disc_cnt != 2'd0) begin
                disc_cnt <= disc_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cancel && !accept) begin
            br_target_reg <= pre_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid    <= 1'b0;
            if_ir_valid <= 1'b0;
        end else if (cancel) begin
            if_valid    <= accept;          // the redirect request itself
            if_ir_valid <= 1'b0;
        end else if (if_allowin) begin
            if_valid    <= pre_if_reqed | accept;
            if_ir_valid <= pre_if_reqed & (pre_if_ir_valid | data_for_pre);
        end else if (data_for_if) begin
            if_ir_valid <= 1'b1;            // decode stalled, park the word
        end
    end

    always_ff @(posedge clk) begin
        if (pre_move && !cancel) begin
            if_pc <= pre_if_pc;
            if_ir <= pre_if_ir_valid ? pre_if_ir : inst_word_u'(inst_sram_rdata);
        end else begin
            if (if_allowin || cancel) begin
                if_pc <= pre_pc;
            end
            if (data_for_if) begin
                if_ir <= inst_sram_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_if_reqed    <= 1'b0;
            pre_if_ir_valid <= 1'b0;
        end else if (cancel) begin
            pre_if_reqed    <= 1'b0;
            pre_if_ir_valid <= 1'b0;
        end else if (pre_move) begin
            pre_if_reqed    <= accept;
            pre_if_ir_valid <= 1'b0;
        end else if (!pre_if_reqed) begin
            pre_if_reqed    <= accept & ~if_allowin;
            pre_if_ir_valid <= 1'b0;
        end else if (data_for_pre) begin
            pre_if_ir_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pre_if_pc <= pre_pc;
        end
        if (data_for_pre) begin
            pre_if_ir <= inst_sram_rdata;
        end
    end

    a_no_stray_data: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_data_ok |-> outst != 2'd0);

    // offered word stays offered until decode takes it, unless redirected
    a_valid_hold: assert property (@(posedge clk) disable iff (!resetn)
        fid.valid && !fid.allowin |=> fid.valid || cancel);
endmodule

`default_nettype wire

// File: hw/id_stage.sv
`default_nettype none
`include "fetch_macros.svh"

module id_stage
    import fetch_pkg::*;
(
    input  wire         clk,
    input  wire         resetn,
    fetch_id_if.decode  fid,
    input  wire         out_ready,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output logic [31:0] out_inst,
    output logic        out_excep,
    output logic        excep_hold
);
    logic        id_valid;
    logic        id_first;      // first cycle the current word is held
    logic [31:0] id_pc;
    inst_word_u  id_inst;
    logic        id_adef;

    logic        transfer;
    logic        is_br;
    logic [25:0] br_offs;

    assign transfer    = fid.valid & fid.allowin;
    assign fid.allowin = out_ready | ~id_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
            id_first <= 1'b0;
        end else begin
            id_first <= transfer;
            if (transfer) begin
                id_valid <= 1'b1;
            end else if (out_ready) begin
                id_valid <= 1'b0;       // retired, nothing new behind it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            id_pc   <= fid.pc;
            id_inst <= fid.inst;
            id_adef <= fid.adef;
        end
    end

    // B/BL only, offset is split across the word
    assign is_br   = (id_inst.br.opcode == `OP_B) || (id_inst.br.opcode == `OP_BL);
    assign br_offs = {id_inst.br.offs_hi, id_inst.br.offs_lo};

    assign fid.br_target = id_pc + {{4{br_offs[25]}}, br_offs, 2'b00};
    assign fid.br_taken  = id_valid & id_first & is_br & ~id_adef;

    assign excep_hold = id_valid & id_first & id_adef;

    assign out_valid = id_valid;
    assign out_pc    = id_pc;
    assign out_inst  = id_inst.raw;
    assign out_excep = id_adef;

    a_one_redirect: assert property (@(posedge clk) disable iff (!resetn)
        !(fid.br_taken && excep_hold));
endmodule

`default_nettype wire

// File: hw/excep_ctrl.sv
`default_nettype none
`include "fetch_macros.svh"

module excep_ctrl (
    input  wire         clk,
    input  wire         resetn,
    input  wire         cfg_we,
    input  wire  [31:0] cfg_wdata,
    input  wire         excep_hold,
    output logic        flush,
    output logic [31:0] excep_entry
);
    logic [31:0] eentry;        // exception entry address

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry <= `FETCH_EENTRY_RESET;
        end else if (cfg_we) begin
            eentry <= cfg_wdata;
        end
    end

    // address error held in decode redirects fetch to the entry
    assign flush       = excep_hold;
    assign excep_entry = eentry;    // a write in the flush cycle lands after it

    // fetch would fault again on a misaligned entry
    a_entry_aligned: assert property (@(posedge clk) disable iff (!resetn)
        eentry[1:0] == 2'b00);
endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`default_nettype none

module fetch_top (
    input  wire         clk,
    input  wire         resetn,
    // instruction sram port
    output logic        inst_sram_req,
    output logic        inst_sram_wr,
    output logic [1:0]  inst_sram_size,
    output logic [3:0]  inst_sram_wstrb,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  wire         inst_sram_addr_ok,
    input  wire         inst_sram_data_ok,
    input  wire  [31:0] inst_sram_rdata,
    // retired words
    input  wire         out_ready,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output logic [31:0] out_inst,
    output logic        out_excep,
    // exception entry write
    input  wire         cfg_we,
    input  wire  [31:0] cfg_wdata
);
    logic        flush;
    logic [31:0] excep_entry;
    logic        excep_hold;

    fetch_id_if fid ();

    if_stage u_if_stage (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_wr      (inst_sram_wr),
        .inst_sram_size    (inst_sram_size),
        .inst_sram_wstrb   (inst_sram_wstrb),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .flush             (flush),
        .excep_entry       (excep_entry),
        .fid               (fid)
    );

    id_stage u_id_stage (
        .clk        (clk),
        .resetn     (resetn),
        .fid        (fid),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_inst   (out_inst),
        .out_excep  (out_excep),
        .excep_hold (excep_hold)
    );

    excep_ctrl u_excep_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .cfg_we      (cfg_we),
        .cfg_wdata   (cfg_wdata),
        .excep_hold  (excep_hold),
        .flush       (flush),
        .excep_entry (excep_entry)
    );
endmodule

`default_nettype wire

// File: testbench/tb_inst_mem.sv
`default_nettype none

module tb_inst_mem (
    input  wire         clk,
    input  wire         resetn,
    input  wire         req,
    input  wire  [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] prog [0:16383];    // word index is addr[15:2]
    logic [31:0] pend [$];          // accepted addresses, oldest first
    integer      seed;
    integer      roll;

    // distinct per address, opcode 000011 is never B/BL
    function automatic logic [31:0] filler(input logic [31:0] a);
        return {6'h03, a[25:2] ^ {18'd0, a[31:26]}, 2'b01};
    endfunction

    initial begin
        seed    = 32'hf9758176;
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = 32'd0;
        for (int i = 0; i < 16384; i++) begin
            prog[i] = filler({16'h1c00, i[13:0], 2'b00});
        end
    end

    // handshakes seen on the rising edge
    always @(posedge clk) begin
        if (!resetn) begin
            pend.delete();
        end else begin
            if (data_ok) begin
                void'(pend.pop_front());
            end
            if (req && addr_ok) begin
                pend.push_back(addr);
            end
        end
    end

    // next cycle's answers, random latency on both sides
    always @(negedge clk) begin
        roll    = $random(seed);
        addr_ok = (roll[1:0] != 2'b00);     // accept 3 cycles in 4
        data_ok = (pend.size() != 0) && (roll[3:2] != 2'b00);
        if (data_ok) begin
            rdata = prog[pend[0][15:2]];    // low address bits ignored
        end else begin
            rdata = 32'h0badf00d;           // junk, not a branch
        end
    end
endmodule

`default_nettype wire

// File: testbench/tb_fetch_top.sv
`default_nettype none
`include "fetch_macros.svh"

module tb_fetch_top
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_RETIRE  = 240;
    localparam int          STALL_LIMIT = 200;  // cycles without a retire
    localparam logic [31:0] NEW_ENTRY   = 32'h1c003000;

    logic        clk;
    logic        resetn;
    logic        inst_sram_req;
    logic        inst_sram_wr;
    logic [1:0]  inst_sram_size;
    logic [3:0]  inst_sram_wstrb;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic        inst_sram_addr_ok;
    logic        inst_sram_data_ok;
    logic [31:0] inst_sram_rdata;
    logic        out_ready;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    logic        out_excep;
    logic        cfg_we;
    logic [31:0] cfg_wdata;

    integer      seed;
    integer      errors;
    integer      retired;
    logic [31:0] exp_pc;        // pc of the next word that should retire
    logic [31:0] exp_entry;
    logic [31:0] br_from [$];   // placed branches and where each one goes
    logic [31:0] br_to [$];

    fetch_top DUT (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_wr      (inst_sram_wr),
        .inst_sram_size    (inst_sram_size),
        .inst_sram_wstrb   (inst_sram_wstrb),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .out_ready         (out_ready),
        .out_valid         (out_valid),
        .out_pc            (out_pc),
        .out_inst          (out_inst),
        .out_excep         (out_excep),
        .cfg_we            (cfg_we),
        .cfg_wdata         (cfg_wdata)
    );

    tb_inst_mem u_mem (
        .clk     (clk),
        .resetn  (resetn),
        .req     (inst_sram_req),
        .addr    (inst_sram_addr),
        .addr_ok (inst_sram_addr_ok),
        .data_ok (inst_sram_data_ok),
        .rdata   (inst_sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] branch_word(input logic [5:0] op,
                                                input logic [31:0] from,
                                                input logic [31:0] to);
        inst_word_u  w;
        logic [31:0] offs;
        offs         = (to - from) >> 2;    // only the low 26 bits are kept
        w.br.opcode  = op;
        w.br.offs_lo = offs[15:0];
        w.br.offs_hi = offs[25:16];
        return w.raw;
    endfunction

    task automatic place_branch(input logic [5:0] op, input logic [31:0] from,
                                input logic [31:0] to);
        u_mem.prog[from[15:2]] = branch_word(op, from, to);
        br_from.push_back(from);
        br_to.push_back(to);
    endtask

    // one loop of hops: forward, backward, long, short, branch onto branch
    task automatic load_program();
        place_branch(`OP_B,  32'h1c000020, 32'h1c000100);
        place_branch(`OP_BL, 32'h1c000118, 32'h1c000040);
        place_branch(`OP_B,  32'h1c000054, 32'h1c001000);
        place_branch(`OP_B,  32'h1c001008, 32'h1c001010);
        place_branch(`OP_BL, 32'h1c001010, 32'h1c002000);
        place_branch(`OP_B,  32'h1c002000, 32'h1c000020);
    endtask

    // unaligned pc traps to the entry, a placed branch jumps, anything else falls through
    function automatic logic [31:0] next_pc(input logic [31:0] pc);
        if (pc[1:0] != 2'b00) begin
            return exp_entry;
        end
        for (int i = 0; i < br_from.size(); i++) begin
            if (br_from[i] == pc) begin
                return br_to[i];
            end
        end
        return pc + 32'd4;
    endfunction

    task automatic note_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        errors = errors + 1;
        $display("FAIL %s: expected %h, actual %h (retire %0d)",
                 name, expected, actual, retired);
    endtask

    task automatic note_error(input string what);
        errors = errors + 1;
        $display("%s", what);
    endtask

    task automatic check_retire();
        logic [31:0] exp_inst;
        exp_inst = u_mem.prog[exp_pc[15:2]];
        a_pc: assert (out_pc == exp_pc)
            else note_mismatch("retire_pc", exp_pc, out_pc);
        a_inst: assert (out_inst == exp_inst)
            else note_mismatch("retire_inst", exp_inst, out_inst);
        a_excep: assert (out_excep == (exp_pc[1:0] != 2'b00))
            else note_mismatch("retire_excep", exp_pc[1:0] != 2'b00, out_excep);
        exp_pc  = next_pc(exp_pc);
        retired = retired + 1;
    endtask

    always @(posedge clk) begin
        if (resetn && out_valid && out_ready) begin
            check_retire();
        end
    end

    // every request is a plain word read with the write side idle
    always @(posedge clk) begin
        if (resetn && inst_sram_req) begin
            a_req_wr: assert (inst_sram_wr === 1'b0)
                else note_mismatch("req_wr", 32'd0, inst_sram_wr);
            a_req_size: assert (inst_sram_size === 2'd2)
                else note_mismatch("req_size", 32'd2, inst_sram_size);
            a_req_wstrb: assert (inst_sram_wstrb === 4'b0000)
                else note_mismatch("req_wstrb", 32'd0, inst_sram_wstrb);
            a_req_wdata: assert (inst_sram_wdata === 32'd0)
                else note_mismatch("req_wdata", 32'd0, inst_sram_wdata);
        end
    end

    initial begin
        integer idle;
        integer last;
        integer roll;
        logic   timed_out;
        resetn    = 1'b0;
        out_ready = 1'b0;
        cfg_we    = 1'b0;
        cfg_wdata = 32'd0;
        seed      = 32'hf9758176;
        errors    = 0;
        retired   = 0;
        timed_out = 1'b0;
        exp_pc    = `FETCH_RESET_PC + 32'd4;
        exp_entry = `FETCH_EENTRY_RESET;

        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            if (c == 0) begin
                load_program();     // memory fill is done by now
            end
            a_reset_req: assert (inst_sram_req === 1'b0)
                else note_error("inst_sram_req is high while resetn is low");
            a_reset_valid: assert (out_valid === 1'b0)
                else note_error("out_valid is high during reset");
        end
        resetn    = 1'b1;
        out_ready = 1'b1;

        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_wdata = NEW_ENTRY;
        exp_entry = NEW_ENTRY;      // targets are word multiples, trap stays unused here
        @(negedge clk);
        cfg_we    = 1'b0;

        idle = 0;
        last = retired;
        while (retired < NUM_RETIRE && !timed_out) begin
            @(negedge clk);
            if (retired != last) begin
                idle = 0;
                last = retired;
            end else begin
                idle = idle + 1;
            end
            if (idle > STALL_LIMIT) begin
                timed_out = 1'b1;
                note_error($sformatf("timeout: no word retired in %0d cycles", STALL_LIMIT));
            end
            roll      = $random(seed);
            out_ready = (retired < 40) ? 1'b1 : roll[0];    // then random back-pressure
        end

        $display("retired %0d of %0d words, %0d errors", retired, NUM_RETIRE, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: filelist.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_id_if.sv
hw/if_stage.sv
hw/id_stage.sv
hw/excep_ctrl.sv
hw/fetch_top.sv
testbench/tb_inst_mem.sv
testbench/tb_fetch_top.sv
